// File: auth_pkg.sv
// Identity widths, provider identity, timing defaults and the link message union
package auth_pkg;

    // ########################################################################
    // Widths
    // ########################################################################

    // Every identity and key
    localparam int ID_W = 64;

    // One link message, two identity-width fields
    localparam int MSG_W = 2 * ID_W;

    // Service-provider identity mixed into both registrations
    localparam logic [ID_W-1:0] USP_ID = 64'hDDDD_DDDD_DDDD_DDDD;

    // ########################################################################
    // Timing defaults
    // ########################################################################

    // Side timeout in cycles, fits in 24 bits
    localparam int DEFAULT_TIMEOUT = 10_000_000;

    // Link depth in register stages
    localparam int DEFAULT_LINK_DELAY = 2;

    // ########################################################################
    // Link message
    // ########################################################################

    // Request view is written by the EV, response view by the CS
    typedef union packed {
        struct packed {
            logic [ID_W-1:0] pseudo_id;
            logic [ID_W-1:0] pub_key;
        } req;
        struct packed {
            logic [ID_W-1:0] cs_id;
            logic [ID_W-1:0] pub_key;
        } rsp;
    } auth_msg_u;

endpackage

// File: auth_session.sv
// Session tracker for the active flag, sticky mutual result and session timeout
`timescale 1ns/1ps

module auth_session #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic clk,
    input  logic rst,
    input  logic start_i,
    input  logic ev_success_i,
    input  logic cs_success_i,
    input  logic ev_fail_i,
    input  logic cs_fail_i,
    output logic active_o,
    output logic mutual_o
);

    localparam int LIMIT = 2 * TIMEOUT_CYCLES;
    localparam int CNT_W = $clog2(LIMIT + 1);

    logic [CNT_W-1:0] sess_cnt_q;
    logic             ev_seen_q;
    logic             cs_seen_q;
    logic             ev_seen;
    logic             cs_seen;

    // Include this cycle's pulses so both-seen is caught at once
    assign ev_seen = ev_seen_q || ev_success_i;
    assign cs_seen = cs_seen_q || cs_success_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_o   <= 1'b0;
            mutual_o   <= 1'b0;
            ev_seen_q  <= 1'b0;
            cs_seen_q  <= 1'b0;
            sess_cnt_q <= '0;
        end else if (start_i) begin
            active_o   <= 1'b1;
            mutual_o   <= 1'b0;
            ev_seen_q  <= 1'b0;
            cs_seen_q  <= 1'b0;
            sess_cnt_q <= '0;
        end else if (active_o) begin
            ev_seen_q  <= ev_seen;
            cs_seen_q  <= cs_seen;
            sess_cnt_q <= sess_cnt_q + 1'b1;
            if (ev_fail_i || cs_fail_i || sess_cnt_q >= CNT_W'(LIMIT)) begin
                active_o <= 1'b0;
            end else if (ev_seen && cs_seen) begin
                mutual_o <= 1'b1;
                active_o <= 1'b0;
            end
        end
    end

endmodule

// File: auth_system_asserts.sv
// Concurrent assertions on the top level, bound into auth_system_top
`timescale 1ns/1ps

module auth_system_asserts #(
    parameter int LINK_DELAY = 2
) (
    input logic clk,
    input logic rst,
    input logic start_i,
    input logic mutual_i,
    input logic ev_ok_i,
    input logic cs_ok_i,
    input logic active_i,
    input logic ev_tx_valid_i,
    input logic cs_rx_valid_i,
    input logic cs_tx_valid_i,
    input logic ev_rx_valid_i
);

    // Count of failed assertions
    int fail_count = 0;

    mutual_needs_both: assert property (@(posedge clk) disable iff (rst)
        mutual_i |-> (ev_ok_i && cs_ok_i))
        else begin
            $error("mutual status high without both side statuses");
            fail_count++;
        end

    // Session stays idle through the first cycle out of reset without a start
    idle_after_reset: assert property (@(posedge clk)
        ($fell(rst) && !start_i) |=> !active_i)
        else begin
            $error("session active in the cycle after reset");
            fail_count++;
        end

    // Each link delays its valid by exactly LINK_DELAY cycles
    ev_to_cs_latency: assert property (@(posedge clk) disable iff (rst)
        cs_rx_valid_i == $past(ev_tx_valid_i, LINK_DELAY))
        else begin
            $error("EV to CS link valid latency wrong");
            fail_count++;
        end

    cs_to_ev_latency: assert property (@(posedge clk) disable iff (rst)
        ev_rx_valid_i == $past(cs_tx_valid_i, LINK_DELAY))
        else begin
            $error("CS to EV link valid latency wrong");
            fail_count++;
        end

endmodule

bind auth_system_top auth_system_asserts #(.LINK_DELAY(LINK_DELAY)) u_asserts (
    .clk           (clk),
    .rst           (rst),
    .start_i       (start_authentication_i),
    .mutual_i      (mutual_auth_status_o),
    .ev_ok_i       (ev_auth_status_o),
    .cs_ok_i       (cs_auth_status_o),
    .active_i      (auth_process_active_o),
    .ev_tx_valid_i (ev_tx_valid),
    .cs_rx_valid_i (cs_rx_valid),
    .cs_tx_valid_i (cs_tx_valid),
    .ev_rx_valid_i (ev_rx_valid)
);

// File: auth_system_top.sv
// Top level joining registration, both links, both auth FSMs and the session tracker
`timescale 1ns/1ps

module auth_system_top #(
    parameter int TIMEOUT_CYCLES = auth_pkg::DEFAULT_TIMEOUT,
    parameter int LINK_DELAY     = auth_pkg::DEFAULT_LINK_DELAY
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start_registration_ev_i,
    input  logic                      start_registration_cs_i,
    input  logic                      start_authentication_i,
    input  logic [auth_pkg::ID_W-1:0] ev_raw_id_i,
    input  logic [auth_pkg::ID_W-1:0] ev_pub_key_i,
    input  logic [auth_pkg::ID_W-1:0] cs_raw_id_i,
    input  logic [auth_pkg::ID_W-1:0] cs_pub_key_i,
    output logic                      ev_reg_status_o,
    output logic                      cs_reg_status_o,
    output logic [auth_pkg::ID_W-1:0] ev_pseudo_id_o,
    output logic [auth_pkg::ID_W-1:0] cs_id_o,
    output logic                      ev_auth_status_o,
    output logic                      cs_auth_status_o,
    output logic                      mutual_auth_status_o,
    output logic                      auth_process_active_o
);

    logic [auth_pkg::ID_W-1:0] ev_key;
    logic [auth_pkg::ID_W-1:0] cs_key;

    // EV to CS path
    logic                ev_tx_valid;
    auth_pkg::auth_msg_u ev_tx_msg;
    logic                cs_rx_valid;
    auth_pkg::auth_msg_u cs_rx_msg;

    // CS to EV path
    logic                cs_tx_valid;
    auth_pkg::auth_msg_u cs_tx_msg;
    logic                ev_rx_valid;
    auth_pkg::auth_msg_u ev_rx_msg;

    logic ev_success;
    logic ev_fail;
    logic cs_success;
    logic cs_fail;

    // ########################################################################
    // Registration
    // ########################################################################

    ev_registration u_ev_reg (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_registration_ev_i),
        .raw_id_i     (ev_raw_id_i),
        .pub_key_i    (ev_pub_key_i),
        .pseudo_id_o  (ev_pseudo_id_o),
        .pub_key_o    (ev_key),
        .registered_o (ev_reg_status_o)
    );

    cs_registration u_cs_reg (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_registration_cs_i),
        .raw_id_i     (cs_raw_id_i),
        .pub_key_i    (cs_pub_key_i),
        .id_o         (cs_id_o),
        .pub_key_o    (cs_key),
        .registered_o (cs_reg_status_o)
    );

    // ########################################################################
    // Authentication and links
    // ########################################################################

    ev_auth_fsm #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_ev_auth (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start_authentication_i),
        .registered_i  (ev_reg_status_o),
        .self_id_i     (ev_pseudo_id_o),
        .self_key_i    (ev_key),
        .known_cs_id_i (cs_id_o),
        .rx_valid_i    (ev_rx_valid),
        .rx_msg_i      (ev_rx_msg),
        .tx_valid_o    (ev_tx_valid),
        .tx_msg_o      (ev_tx_msg),
        .auth_ok_o     (ev_auth_status_o),
        .success_o     (ev_success),
        .fail_o        (ev_fail)
    );

    cs_auth_fsm #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_cs_auth (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start_authentication_i),
        .registered_i  (cs_reg_status_o),
        .self_id_i     (cs_id_o),
        .self_key_i    (cs_key),
        .known_ev_id_i (ev_pseudo_id_o),
        .rx_valid_i    (cs_rx_valid),
        .rx_msg_i      (cs_rx_msg),
        .tx_valid_o    (cs_tx_valid),
        .tx_msg_o      (cs_tx_msg),
        .auth_ok_o     (cs_auth_status_o),
        .success_o     (cs_success),
        .fail_o        (cs_fail)
    );

    msg_link #(.LINK_DELAY(LINK_DELAY)) link_ev_to_cs (
        .clk     (clk),
        .rst     (rst),
        .valid_i (ev_tx_valid),
        .msg_i   (ev_tx_msg),
        .valid_o (cs_rx_valid),
        .msg_o   (cs_rx_msg)
    );

    msg_link #(.LINK_DELAY(LINK_DELAY)) link_cs_to_ev (
        .clk     (clk),
        .rst     (rst),
        .valid_i (cs_tx_valid),
        .msg_i   (cs_tx_msg),
        .valid_o (ev_rx_valid),
        .msg_o   (ev_rx_msg)
    );

    auth_session #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_session (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_authentication_i),
        .ev_success_i (ev_success),
        .cs_success_i (cs_success),
        .ev_fail_i    (ev_fail),
        .cs_fail_i    (cs_fail),
        .active_o     (auth_process_active_o),
        .mutual_o     (mutual_auth_status_o)
    );

endmodule

// File: cs_auth_fsm.sv
// CS authentication FSM verifying the EV request and sending the response
`timescale 1ns/1ps

module cs_auth_fsm #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start_i,
    input  logic                      registered_i,
    input  logic [auth_pkg::ID_W-1:0] self_id_i,
    input  logic [auth_pkg::ID_W-1:0] self_key_i,
    input  logic [auth_pkg::ID_W-1:0] known_ev_id_i,
    input  logic                      rx_valid_i,
    input  auth_pkg::auth_msg_u       rx_msg_i,
    output logic                      tx_valid_o,
    output auth_pkg::auth_msg_u       tx_msg_o,
    output logic                      auth_ok_o,
    output logic                      success_o,
    output logic                      fail_o
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_WAIT   = 2'd1;
    localparam logic [1:0] S_VERIFY = 2'd2;

    logic [1:0]       state_q;
    logic [CNT_W-1:0] wait_cnt_q;
    logic             match_q;

    // Response goes out only to a recognised EV
    assign tx_valid_o           = (state_q == S_VERIFY) && match_q;
    assign tx_msg_o.rsp.cs_id   = self_id_i;
    assign tx_msg_o.rsp.pub_key = self_key_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= S_IDLE;
            wait_cnt_q <= '0;
            match_q    <= 1'b0;
            auth_ok_o  <= 1'b0;
            success_o  <= 1'b0;
            fail_o     <= 1'b0;
        end else begin
            success_o <= 1'b0;
            fail_o    <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    wait_cnt_q <= '0;
                    if (start_i) begin
                        auth_ok_o <= 1'b0;
                    end
                    if (start_i && registered_i) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (rx_valid_i) begin
                        match_q <= (rx_msg_i.req.pseudo_id == known_ev_id_i);
                        state_q <= S_VERIFY;
                    end else if (wait_cnt_q >= CNT_W'(TIMEOUT_CYCLES)) begin
                        fail_o  <= 1'b1;
                        state_q <= S_IDLE;
                    end else begin
                        wait_cnt_q <= wait_cnt_q + 1'b1;
                    end
                end
                default: begin
                    auth_ok_o <= match_q;
                    success_o <= match_q;
                    fail_o    <= !match_q;
                    state_q   <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// File: cs_registration.sv
// CS registration FSM deriving and holding the station identity and public key
`timescale 1ns/1ps

module cs_registration (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_i,
    input  logic [auth_pkg::ID_W-1:0] raw_id_i,
    input  logic [auth_pkg::ID_W-1:0] pub_key_i,
    output logic [auth_pkg::ID_W-1:0] id_o,
    output logic [auth_pkg::ID_W-1:0] pub_key_o,
    output logic                     registered_o
);

    localparam logic [1:0] S_IDLE     = 2'd0;
    localparam logic [1:0] S_DERIVE   = 2'd1;
    localparam logic [1:0] S_COMPLETE = 2'd2;

    logic [1:0] state_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= S_IDLE;
            registered_o <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE:   if (start_i) state_q <= S_DERIVE;
                S_DERIVE: state_q <= S_COMPLETE;
                default: begin
                    registered_o <= 1'b1;
                    state_q      <= S_IDLE;
                end
            endcase
        end
    end

    // Identity and key latch together in one cycle
    always_ff @(posedge clk) begin
        if (state_q == S_DERIVE) begin
            id_o      <= raw_id_i ^ auth_pkg::USP_ID;
            pub_key_o <= pub_key_i;
        end
    end

endmodule

// File: ev_auth_fsm.sv
// EV authentication FSM sending the request and verifying the CS response
`timescale 1ns/1ps

module ev_auth_fsm #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start_i,
    input  logic                      registered_i,
    input  logic [auth_pkg::ID_W-1:0] self_id_i,
    input  logic [auth_pkg::ID_W-1:0] self_key_i,
    input  logic [auth_pkg::ID_W-1:0] known_cs_id_i,
    input  logic                      rx_valid_i,
    input  auth_pkg::auth_msg_u       rx_msg_i,
    output logic                      tx_valid_o,
    output auth_pkg::auth_msg_u       tx_msg_o,
    output logic                      auth_ok_o,
    output logic                      success_o,
    output logic                      fail_o
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_REQUEST = 2'd1;
    localparam logic [1:0] S_WAIT    = 2'd2;
    localparam logic [1:0] S_VERIFY  = 2'd3;

    logic [1:0]       state_q;
    logic [CNT_W-1:0] wait_cnt_q;
    logic             match_q;

    // One request, sent for the single cycle spent in S_REQUEST
    assign tx_valid_o             = (state_q == S_REQUEST);
    assign tx_msg_o.req.pseudo_id = self_id_i;
    assign tx_msg_o.req.pub_key   = self_key_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= S_IDLE;
            wait_cnt_q <= '0;
            match_q    <= 1'b0;
            auth_ok_o  <= 1'b0;
            success_o  <= 1'b0;
            fail_o     <= 1'b0;
        end else begin
            success_o <= 1'b0;
            fail_o    <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        auth_ok_o <= 1'b0;
                    end
                    // Unregistered EV stays idle and the CS times out
                    if (start_i && registered_i) begin
                        state_q <= S_REQUEST;
                    end
                end
                S_REQUEST: begin
                    wait_cnt_q <= '0;
                    state_q    <= S_WAIT;
                end
                S_WAIT: begin
                    if (rx_valid_i) begin
                        match_q <= (rx_msg_i.rsp.cs_id == known_cs_id_i);
                        state_q <= S_VERIFY;
                    end else if (wait_cnt_q >= CNT_W'(TIMEOUT_CYCLES)) begin
                        fail_o  <= 1'b1;
                        state_q <= S_IDLE;
                    end else begin
                        wait_cnt_q <= wait_cnt_q + 1'b1;
                    end
                end
                default: begin
                    auth_ok_o <= match_q;
                    success_o <= match_q;
                    fail_o    <= !match_q;
                    state_q   <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// File: ev_registration.sv
// EV registration FSM deriving and holding the pseudo-identity and public key
`timescale 1ns/1ps

module ev_registration (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_i,
    input  logic [auth_pkg::ID_W-1:0] raw_id_i,
    input  logic [auth_pkg::ID_W-1:0] pub_key_i,
    output logic [auth_pkg::ID_W-1:0] pseudo_id_o,
    output logic [auth_pkg::ID_W-1:0] pub_key_o,
    output logic                     registered_o
);

    localparam logic [1:0] S_IDLE     = 2'd0;
    localparam logic [1:0] S_DERIVE   = 2'd1;
    localparam logic [1:0] S_LATCH    = 2'd2;
    localparam logic [1:0] S_COMPLETE = 2'd3;

    logic [1:0] state_q;

    // Sequencing and sticky registered flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= S_IDLE;
            registered_o <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE:     if (start_i) state_q <= S_DERIVE;
                S_DERIVE:   state_q <= S_LATCH;
                S_LATCH:    state_q <= S_COMPLETE;
                default: begin
                    registered_o <= 1'b1;
                    state_q      <= S_IDLE;
                end
            endcase
        end
    end

    // Credential registers
    always_ff @(posedge clk) begin
        if (state_q == S_DERIVE) begin
            pseudo_id_o <= raw_id_i ^ auth_pkg::USP_ID;
        end
        if (state_q == S_LATCH) begin
            pub_key_o <= pub_key_i;
        end
    end

endmodule

// File: msg_link.sv
// Fixed-depth delay line carrying a valid flag and message between the sides
`timescale 1ns/1ps

module msg_link #(
    parameter int LINK_DELAY = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_i,
    input  auth_pkg::auth_msg_u msg_i,
    output logic                valid_o,
    output auth_pkg::auth_msg_u msg_o
);

    // Layout does not matter here, the stages hold raw message bits
    logic [LINK_DELAY-1:0]      vld_q;
    logic [auth_pkg::MSG_W-1:0] msg_q [LINK_DELAY];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= valid_i;
            for (int i = 1; i < LINK_DELAY; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        msg_q[0] <= msg_i;
        for (int i = 1; i < LINK_DELAY; i++) begin
            msg_q[i] <= msg_q[i-1];
        end
    end

    assign valid_o = vld_q[LINK_DELAY-1];
    assign msg_o   = msg_q[LINK_DELAY-1];

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; pass only if the pass message is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_auth_system -o tb_auth_system || exit 1

out=$(./obj_dir/tb_auth_system 2>&1)
echo "$out"
echo "$out" | grep -q "Finished with no errors" && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}

// File: sim.f
auth_pkg.sv
msg_link.sv
ev_registration.sv
cs_registration.sv
ev_auth_fsm.sv
cs_auth_fsm.sv
auth_session.sv
auth_system_top.sv
auth_system_asserts.sv
tb_auth_system.sv

// File: tb_auth_system.sv
// Directed testbench with clock, reset, value check, watchdog and the authentication tests
`timescale 1ns/1ps

module tb_auth_system;

    localparam int TIMEOUT_CYCLES  = 64;
    localparam int LINK_DELAY      = 3;
    localparam int CLK_PERIOD      = 4;
    localparam int AUTH_LIMIT      = 4 * LINK_DELAY + 10;
    localparam int ONE_SIDED_LIMIT = 2 * TIMEOUT_CYCLES + 10;
    localparam int WATCHDOG_CYCLES = 5 * (2 * TIMEOUT_CYCLES + 4 * LINK_DELAY + 50);

    logic        clk;
    logic        rst;
    logic        start_reg_ev;
    logic        start_reg_cs;
    logic        start_auth;
    logic [63:0] ev_raw_id;
    logic [63:0] ev_pub_key;
    logic [63:0] cs_raw_id;
    logic [63:0] cs_pub_key;
    logic        ev_reg_status;
    logic        cs_reg_status;
    logic [63:0] ev_pseudo_id;
    logic [63:0] cs_id;
    logic        ev_auth_status;
    logic        cs_auth_status;
    logic        mutual;
    logic        active;

    auth_system_top #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
        .LINK_DELAY     (LINK_DELAY)
    ) UUT (
        .clk                     (clk),
        .rst                     (rst),
        .start_registration_ev_i (start_reg_ev),
        .start_registration_cs_i (start_reg_cs),
        .start_authentication_i  (start_auth),
        .ev_raw_id_i             (ev_raw_id),
        .ev_pub_key_i            (ev_pub_key),
        .cs_raw_id_i             (cs_raw_id),
        .cs_pub_key_i            (cs_pub_key),
        .ev_reg_status_o         (ev_reg_status),
        .cs_reg_status_o         (cs_reg_status),
        .ev_pseudo_id_o          (ev_pseudo_id),
        .cs_id_o                 (cs_id),
        .ev_auth_status_o        (ev_auth_status),
        .cs_auth_status_o        (cs_auth_status),
        .mutual_auth_status_o    (mutual),
        .auth_process_active_o   (active)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ########################################################################
    // Helpers
    // ########################################################################

    // Drive and sample 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s actual=%0h expected=%0h", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s at time %0t", what, $time);
        $display("Finished with errors");
        $fatal(1, "bounded wait expired");
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (8) next_cycle();
        rst = 1'b0;
    endtask

    // Fresh random credentials before the selected registrations
    task automatic register_sides(input bit do_ev, input bit do_cs);
        ev_raw_id    = {$urandom, $urandom};
        ev_pub_key   = {$urandom, $urandom};
        cs_raw_id    = {$urandom, $urandom};
        cs_pub_key   = {$urandom, $urandom};
        start_reg_ev = do_ev;
        start_reg_cs = do_cs;
        next_cycle();
        start_reg_ev = 1'b0;
        start_reg_cs = 1'b0;
        repeat (2) next_cycle();
        // CS completes after 2 edges and EV after 3
        if (do_cs) begin
            check_value("cs_reg_status_o", cs_reg_status, 1);
            check_value("cs_id_o", cs_id, cs_raw_id ^ auth_pkg::USP_ID);
        end
        next_cycle();
        if (do_ev) begin
            check_value("ev_reg_status_o", ev_reg_status, 1);
            check_value("ev_pseudo_id_o", ev_pseudo_id, ev_raw_id ^ auth_pkg::USP_ID);
        end
    endtask

    task automatic run_mutual_auth();
        int cycles;
        start_auth = 1'b1;
        next_cycle();
        start_auth = 1'b0;
        // Start clears the previous result at once
        check_value("mutual_auth_status_o", mutual, 0);
        check_value("auth_process_active_o", active, 1);
        cycles = 1;
        while (mutual !== 1'b1 && cycles < AUTH_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (mutual !== 1'b1) begin
            report_timeout("mutual authentication");
        end
        check_value("ev_auth_status_o", ev_auth_status, 1);
        check_value("cs_auth_status_o", cs_auth_status, 1);
        check_value("auth_process_active_o", active, 0);
    endtask

    // ########################################################################
    // Tests
    // ########################################################################

    task automatic verify_reset_state();
        check_value("ev_reg_status_o", ev_reg_status, 0);
        check_value("cs_reg_status_o", cs_reg_status, 0);
        check_value("ev_auth_status_o", ev_auth_status, 0);
        check_value("cs_auth_status_o", cs_auth_status, 0);
        check_value("mutual_auth_status_o", mutual, 0);
        check_value("auth_process_active_o", active, 0);
    endtask

    task automatic mutual_auth_holds();
        run_mutual_auth();
        repeat (6) next_cycle();
        check_value("mutual_auth_status_o", mutual, 1);
    endtask

    // Only the CS is registered, so the EV never sends and the CS times out
    task automatic one_sided_timeout();
        int cycles;
        apply_reset();
        register_sides(1'b0, 1'b1);
        check_value("ev_reg_status_o", ev_reg_status, 0);
        start_auth = 1'b1;
        next_cycle();
        start_auth = 1'b0;
        check_value("auth_process_active_o", active, 1);
        cycles = 1;
        while (active === 1'b1 && cycles < ONE_SIDED_LIMIT) begin
            check_value("mutual_auth_status_o", mutual, 0);
            check_value("ev_auth_status_o", ev_auth_status, 0);
            check_value("cs_auth_status_o", cs_auth_status, 0);
            next_cycle();
            cycles++;
        end
        if (active !== 1'b0) begin
            report_timeout("one-sided session to end");
        end
        check_value("mutual_auth_status_o", mutual, 0);
        check_value("ev_auth_status_o", ev_auth_status, 0);
        check_value("cs_auth_status_o", cs_auth_status, 0);
    endtask

    task automatic reregister_and_repeat();
        register_sides(1'b1, 1'b1);
        run_mutual_auth();
        next_cycle();
        run_mutual_auth();
    endtask

    initial begin
        void'($urandom(99));
        clk          = 1'b0;
        rst          = 1'b1;
        start_reg_ev = 1'b0;
        start_reg_cs = 1'b0;
        start_auth   = 1'b0;
        ev_raw_id    = '0;
        ev_pub_key   = '0;
        cs_raw_id    = '0;
        cs_pub_key   = '0;
        apply_reset();
        verify_reset_state();
        register_sides(1'b1, 1'b1);
        mutual_auth_holds();
        one_sided_timeout();
        reregister_and_repeat();
        if (UUT.u_asserts.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("%0d assertion failures during the run", UUT.u_asserts.fail_count);
            $display("Finished with errors");
        end
        $finish;
    end

    // Upper bound on the whole run
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $fatal(1, "watchdog");
    end

endmodule
